// File: vlog.f
+incdir+testbench
hw/book_pkg.sv
hw/pipe_pkg.sv
hw/state_table.sv
hw/state_fwd.sv
hw/book_exe.sv
hw/update_pipe.sv
hw/book_update_top.sv
testbench/tb_book_update.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_book_update -Mdir obj_dir
	./obj_dir/Vtb_book_update 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_book_model.svh
// Reference book model and stimulus table with expected notifications, included by the testbench
`ifndef TB_BOOK_MODEL_SVH
`define TB_BOOK_MODEL_SVH

  // Idle cycles drawn at random, 1 to 3
  localparam logic [2:0] GAP_RND = 3'd7;
  localparam int         VOL_MAX = (1 << VOLUME_W) - 1;
  localparam int         ROWS_N  = 34;

  // Stimulus, idle cycles after it, hand-worked expected notify
  typedef struct packed {
    id_t        id;
    cmd_t       cmd;
    key_t       key;
    volume_t    volume;
    logic [2:0] gap;
    logic       exp_vld;
    key_t       exp_key;
    volume_t    exp_vol;
  } row_t;

  row_t rows [ROWS_N] = '{
    // Start every product used from an empty book
    '{4'd1, CMD_CLR, 8'd0,   8'd0,   3'd0,    1'b0, 8'd0,   8'd0},
    '{4'd2, CMD_CLR, 8'd0,   8'd0,   3'd0,    1'b0, 8'd0,   8'd0},
    '{4'd3, CMD_CLR, 8'd0,   8'd0,   3'd0,    1'b0, 8'd0,   8'd0},
    '{4'd4, CMD_CLR, 8'd0,   8'd0,   GAP_RND, 1'b0, 8'd0,   8'd0},
    // First add, then a worse level
    '{4'd1, CMD_ADD, 8'd50,  8'd10,  GAP_RND, 1'b1, 8'd50,  8'd10},
    '{4'd1, CMD_ADD, 8'd60,  8'd5,   GAP_RND, 1'b0, 8'd0,   8'd0},
    // New best, delete back to next best, saturation
    '{4'd1, CMD_ADD, 8'd40,  8'd20,  GAP_RND, 1'b1, 8'd40,  8'd20},
    '{4'd1, CMD_DEL, 8'd40,  8'd25,  GAP_RND, 1'b1, 8'd50,  8'd10},
    '{4'd1, CMD_ADD, 8'd50,  8'd250, GAP_RND, 1'b1, 8'd50,  8'd255},
    '{4'd1, CMD_ADD, 8'd50,  8'd1,   GAP_RND, 1'b0, 8'd0,   8'd0},
    // Spacing 2, 3, 5, 2, 3 on product 2
    '{4'd2, CMD_ADD, 8'd30,  8'd5,   3'd1,    1'b1, 8'd30,  8'd5},
    '{4'd2, CMD_ADD, 8'd30,  8'd7,   3'd2,    1'b1, 8'd30,  8'd12},
    '{4'd2, CMD_ADD, 8'd20,  8'd3,   3'd4,    1'b1, 8'd20,  8'd3},
    '{4'd2, CMD_DEL, 8'd20,  8'd1,   3'd1,    1'b1, 8'd20,  8'd2},
    '{4'd2, CMD_DEL, 8'd20,  8'd2,   3'd2,    1'b1, 8'd30,  8'd12},
    '{4'd2, CMD_ADD, 8'd30,  8'd1,   GAP_RND, 1'b1, 8'd30,  8'd13},
    // Fill product 3 while product 4 interleaves
    '{4'd3, CMD_ADD, 8'd100, 8'd1,   3'd0,    1'b1, 8'd100, 8'd1},
    '{4'd4, CMD_ADD, 8'd9,   8'd9,   3'd0,    1'b1, 8'd9,   8'd9},
    '{4'd3, CMD_ADD, 8'd110, 8'd2,   3'd0,    1'b0, 8'd0,   8'd0},
    '{4'd4, CMD_ADD, 8'd8,   8'd1,   3'd0,    1'b1, 8'd8,   8'd1},
    '{4'd3, CMD_ADD, 8'd120, 8'd3,   3'd0,    1'b0, 8'd0,   8'd0},
    '{4'd4, CMD_DEL, 8'd8,   8'd1,   3'd0,    1'b1, 8'd9,   8'd9},
    '{4'd3, CMD_ADD, 8'd90,  8'd4,   3'd0,    1'b1, 8'd90,  8'd4},
    '{4'd4, CMD_ADD, 8'd9,   8'd1,   3'd0,    1'b1, 8'd9,   8'd10},
    // Full list and absent key are silent
    '{4'd3, CMD_ADD, 8'd50,  8'd5,   GAP_RND, 1'b0, 8'd0,   8'd0},
    '{4'd3, CMD_DEL, 8'd77,  8'd5,   GAP_RND, 1'b0, 8'd0,   8'd0},
    '{4'd3, CMD_DEL, 8'd90,  8'd10,  GAP_RND, 1'b1, 8'd100, 8'd1},
    '{4'd3, CMD_ADD, 8'd50,  8'd5,   GAP_RND, 1'b1, 8'd50,  8'd5},
    // Clear is silent, next add sees an empty book
    '{4'd3, CMD_CLR, 8'd0,   8'd0,   GAP_RND, 1'b0, 8'd0,   8'd0},
    '{4'd3, CMD_ADD, 8'd120, 8'd7,   GAP_RND, 1'b1, 8'd120, 8'd7},
    // Older books untouched by the traffic above
    '{4'd1, CMD_DEL, 8'd50,  8'd100, 3'd0,    1'b1, 8'd50,  8'd155},
    '{4'd2, CMD_DEL, 8'd30,  8'd13,  3'd0,    1'b1, 8'd0,   8'd0},
    '{4'd1, CMD_ADD, 8'd55,  8'd1,   GAP_RND, 1'b0, 8'd0,   8'd0},
    '{4'd4, CMD_DEL, 8'd9,   8'd10,  GAP_RND, 1'b1, 8'd0,   8'd0}
  };

  // Model book, slot order is irrelevant, only the set of levels
  bit mdl_vld [1 << ID_W][ENTRIES_N];
  int mdl_key [1 << ID_W][ENTRIES_N];
  int mdl_vol [1 << ID_W][ENTRIES_N];

  // Smallest valid key, zeros for an empty book
  function automatic void model_best(input int id, output int key, output int vol);
    bit found;
    found = 1'b0;
    key   = 0;
    vol   = 0;
    for (int s = 0; s < ENTRIES_N; s++) begin
      if (mdl_vld[id][s] && (!found || (mdl_key[id][s] < key))) begin
        found = 1'b1;
        key   = mdl_key[id][s];
        vol   = mdl_vol[id][s];
      end
    end
  endfunction

  // Applies one update, returns whether level zero moved
  function automatic bit model_apply(input int id, input cmd_t cmd, input int key,
                                     input int vol, output int n_key, output int n_vol);
    int b_key;
    int b_vol;
    int slot;
    model_best(id, b_key, b_vol);
    slot = -1;
    for (int s = 0; s < ENTRIES_N; s++) begin
      if (mdl_vld[id][s] && (mdl_key[id][s] == key)) begin
        slot = s;
      end
    end
    if (cmd == CMD_ADD) begin
      if (slot >= 0) begin
        mdl_vol[id][slot] = mdl_vol[id][slot] + vol;
        if (mdl_vol[id][slot] > VOL_MAX) begin
          mdl_vol[id][slot] = VOL_MAX;
        end
      end else begin
        // Any free slot will do, none means full
        for (int s = ENTRIES_N - 1; s >= 0; s--) begin
          if (!mdl_vld[id][s]) begin
            slot = s;
          end
        end
        if (slot >= 0) begin
          mdl_vld[id][slot] = 1'b1;
          mdl_key[id][slot] = key;
          mdl_vol[id][slot] = vol;
        end
      end
    end else if (cmd == CMD_DEL) begin
      if (slot >= 0) begin
        if (mdl_vol[id][slot] <= vol) begin
          mdl_vld[id][slot] = 1'b0;
        end else begin
          mdl_vol[id][slot] = mdl_vol[id][slot] - vol;
        end
      end
    end else begin
      for (int s = 0; s < ENTRIES_N; s++) begin
        mdl_vld[id][s] = 1'b0;
      end
    end
    model_best(id, n_key, n_vol);
    return (cmd != CMD_CLR) && ((n_key != b_key) || (n_vol != b_vol));
  endfunction

`endif

// File: testbench/tb_book_update.sv
// Testbench for the book updater, table-driven updates checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_book_update
  import book_pkg::*;
  import pipe_pkg::*;
();

  localparam int PRODUCTS_N   = 16;
  localparam int SEED         = 49608;
  localparam int CLK_HALF     = 20;
  localparam int RST_CYCLES   = 8;
  localparam int DRAIN_CYCLES = 10;

  logic    clk;
  logic    rst;
  upd_t    upd;
  notify_t notify;

  `include "tb_book_model.svh"

  // Worst row costs 1 strobe plus at most 4 idle cycles
  localparam int CYCLE_LIMIT = ROWS_N * 5 + 50;

  // Expected notifications in issue order
  notify_t exp_q [$];
  int      cycle_cnt    = 0;
  int      value_errs   = 0;
  int      missing_errs = 0;
  int      extra_errs   = 0;
  int      table_errs   = 0;

  book_update_top #(
    .PRODUCTS_N (PRODUCTS_N)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .i_upd    (upd),
    .o_notify (notify)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  // Hard stop if the run overstays its budget
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // Notify is registered, stable at the falling edge
  always @(negedge clk) begin
    if (!rst && notify.vld) begin
      check_notify(notify);
    end
  end

  task automatic check_notify(input notify_t got);
    notify_t exp;
    if (exp_q.size() == 0) begin
      extra_errs++;
      $display("Unexpected notification for product %0d at %0t ns, none was pending",
               got.id, $time);
    end else begin
      exp = exp_q.pop_front();
      assert (got.id == exp.id) else begin
        value_errs++;
        $display("** Error at %0t ns: notify id %0d, expected %0d", $time, got.id, exp.id);
      end
      assert (got.key == exp.key) else begin
        value_errs++;
        $display("** Error at %0t ns: product %0d key %0d, expected %0d",
                 $time, exp.id, got.key, exp.key);
      end
      assert (got.volume == exp.volume) else begin
        value_errs++;
        $display("** Error at %0t ns: product %0d volume %0d, expected %0d",
                 $time, exp.id, got.volume, exp.volume);
      end
    end
  endtask

  // Model first, then one strobe, ends 2 ns after the sampling edge
  task automatic drive_row(input row_t r);
    notify_t exp;
    bit      hit;
    int      m_key;
    int      m_vol;
    hit = model_apply(int'(r.id), r.cmd, int'(r.key), int'(r.volume), m_key, m_vol);
    // Hand-worked table entry must match the model
    assert ((hit == r.exp_vld) &&
            (!hit || ((m_key == int'(r.exp_key)) && (m_vol == int'(r.exp_vol))))) else begin
      table_errs++;
      $display("** Error at %0t ns: product %0d table expectation differs from model",
               $time, r.id);
    end
    if (hit) begin
      exp = '{vld: 1'b1, id: r.id, key: key_t'(m_key), volume: volume_t'(m_vol)};
      exp_q.push_back(exp);
    end
    upd = '{vld: 1'b1, id: r.id, cmd: r.cmd, key: r.key, volume: r.volume};
    @(posedge clk);
    #2;
    upd = '0;
  endtask

  initial begin
    int unsigned seed_val;
    int          gap;
    int          wait_cnt;
    seed_val = $urandom(SEED);
    rst      = 1'b1;
    upd      = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int i = 0; i < ROWS_N; i++) begin
      drive_row(rows[i]);
      if (rows[i].gap == GAP_RND) begin
        gap = 1 + int'($urandom % 3);
      end else begin
        gap = int'(rows[i].gap);
      end
      // Same id never in adjacent cycles
      if ((gap == 0) && (i + 1 < ROWS_N) && (rows[i + 1].id == rows[i].id)) begin
        gap = 1;
      end
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end

    // Fixed latency, pending results come out within a few cycles
    wait_cnt = 0;
    while ((exp_q.size() != 0) && (wait_cnt < DRAIN_CYCLES)) begin
      @(posedge clk);
      wait_cnt++;
    end
    // Room for a stray late notification
    repeat (4) @(posedge clk);

    missing_errs = exp_q.size();
    if (missing_errs != 0) begin
      $display("%0d expected notifications never arrived", missing_errs);
    end
    $display("Errors: value %0d, missing %0d, unexpected %0d, table %0d",
             value_errs, missing_errs, extra_errs, table_errs);
    if ((value_errs + missing_errs + extra_errs + table_errs) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/book_update_top.sv
// Book updater top, joins the update pipeline, forwarding unit and state table
`timescale 1ns/1ps
`default_nettype none

module book_update_top
  import book_pkg::*;
  import pipe_pkg::*;
#(
  parameter int PRODUCTS_N = 16
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire upd_t i_upd,
  output notify_t   o_notify
);

  logic   rd_en;
  id_t    rd_id;
  state_t rd_state;
  logic   rd_kill;
  logic   s1_vld;
  id_t    s1_id;
  logic   s2_vld;
  id_t    s2_id;
  state_t s2_state;
  wrbk_t  wrbk;

  update_pipe u_update_pipe (
    .clk        (clk),
    .rst        (rst),
    .i_upd      (i_upd),
    .o_rd_en    (rd_en),
    .o_rd_id    (rd_id),
    .o_s1_vld   (s1_vld),
    .o_s1_id    (s1_id),
    .o_s2_vld   (s2_vld),
    .o_s2_id    (s2_id),
    .i_rd_kill  (rd_kill),
    .i_s2_state (s2_state),
    .o_wrbk     (wrbk),
    .o_notify   (o_notify)
  );

  state_fwd u_state_fwd (
    .clk        (clk),
    .rst        (rst),
    .i_s1_vld   (s1_vld),
    .i_s1_id    (s1_id),
    .i_s2_vld   (s2_vld),
    .i_s2_id    (s2_id),
    .i_wrbk     (wrbk),
    .i_rd_state (rd_state),
    .o_rd_kill  (rd_kill),
    .o_s2_state (s2_state)
  );

  state_table #(
    .PRODUCTS_N (PRODUCTS_N)
  ) u_state_table (
    .clk        (clk),
    .i_rd_en    (rd_en),
    .i_rd_id    (rd_id),
    .o_rd_state (rd_state),
    .i_wrbk     (wrbk)
  );

  // Forwarding has no path for an id in S1 and S2 at once
  a_no_adjacent_id : assert property (@(posedge clk) disable iff (rst)
    (i_upd.vld && $past(i_upd.vld)) |-> (i_upd.id != $past(i_upd.id)))
    else $error("update id %0d repeated in consecutive cycles", i_upd.id);

endmodule

`default_nettype wire

// File: hw/update_pipe.sv
// Update pipeline, S1 to S3 stage registers plus the S4 write-back and notify registers
`timescale 1ns/1ps
`default_nettype none

module update_pipe
  import book_pkg::*;
  import pipe_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire upd_t   i_upd,
  // State table read, issued in S1
  output logic        o_rd_en,
  output id_t         o_rd_id,
  // Stage ids to the forwarding unit
  output logic        o_s1_vld,
  output id_t         o_s1_id,
  output logic        o_s2_vld,
  output id_t         o_s2_id,
  // From the forwarding unit
  input  wire logic   i_rd_kill,
  input  wire state_t i_s2_state,
  // S4 outputs
  output wrbk_t       o_wrbk,
  output notify_t     o_notify
);

  localparam int STAGES_N = 3;

  // Index 0 is S1, 1 is S2, 2 is S3
  upd_t    stg_in [STAGES_N];
  upd_t    stg_r  [STAGES_N];
  state_t  s3_state_r;
  state_t  exe_state;
  notify_t exe_notify;
  wrbk_t   wrbk_r;
  notify_t notify_r;

  // Each stage feeds from the one before
  assign stg_in[0] = i_upd;
  assign stg_in[1] = stg_r[0];
  assign stg_in[2] = stg_r[1];

  // Valids reset, payload loads only with a valid behind it
  always_ff @(posedge clk) begin
    for (int s = 0; s < STAGES_N; s++) begin
      if (rst) begin
        stg_r[s].vld <= 1'b0;
      end else begin
        stg_r[s].vld <= stg_in[s].vld;
      end
      if (stg_in[s].vld) begin
        stg_r[s].id     <= stg_in[s].id;
        stg_r[s].cmd    <= stg_in[s].cmd;
        stg_r[s].key    <= stg_in[s].key;
        stg_r[s].volume <= stg_in[s].volume;
      end
    end
  end

  // Selected state enters S3 alongside its update
  always_ff @(posedge clk) begin
    if (stg_r[1].vld) begin
      s3_state_r <= i_s2_state;
    end
  end

  book_exe u_book_exe (
    .i_cmd    (stg_r[2].cmd),
    .i_key    (stg_r[2].key),
    .i_volume (stg_r[2].volume),
    .i_id     (stg_r[2].id),
    .i_state  (s3_state_r),
    .o_state  (exe_state),
    .o_notify (exe_notify)
  );

  // S4 write-back, every S3 update writes its state
  always_ff @(posedge clk) begin
    if (rst) begin
      wrbk_r.vld <= 1'b0;
    end else begin
      wrbk_r.vld <= stg_r[2].vld;
    end
    if (stg_r[2].vld) begin
      wrbk_r.id    <= stg_r[2].id;
      wrbk_r.state <= exe_state;
    end
  end

  // S4 notify, only on a level zero change
  always_ff @(posedge clk) begin
    if (rst) begin
      notify_r.vld <= 1'b0;
    end else begin
      notify_r.vld <= stg_r[2].vld & exe_notify.vld;
    end
    if (stg_r[2].vld & exe_notify.vld) begin
      notify_r.id     <= exe_notify.id;
      notify_r.key    <= exe_notify.key;
      notify_r.volume <= exe_notify.volume;
    end
  end

  // Read skipped when the write-back collides
  assign o_rd_en  = stg_r[0].vld & ~i_rd_kill;
  assign o_rd_id  = stg_r[0].id;

  assign o_s1_vld = stg_r[0].vld;
  assign o_s1_id  = stg_r[0].id;
  assign o_s2_vld = stg_r[1].vld;
  assign o_s2_id  = stg_r[1].id;

  assign o_wrbk   = wrbk_r;
  assign o_notify = notify_r;

endmodule

`default_nettype wire

// File: hw/book_exe.sv
// S3 execute, applies one command to a product list and flags level zero changes
`timescale 1ns/1ps
`default_nettype none

module book_exe
  import book_pkg::*;
  import pipe_pkg::*;
(
  input  wire cmd_t    i_cmd,
  input  wire key_t    i_key,
  input  wire volume_t i_volume,
  input  wire id_t     i_id,
  input  wire state_t  i_state,
  output state_t       o_state,
  output notify_t      o_notify
);

  // Volume add clamped at all ones
  function automatic volume_t sat_add(volume_t a, volume_t b);
    logic [VOLUME_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[VOLUME_W] ? '1 : sum[VOLUME_W - 1:0];
  endfunction

  // Valid entry with smallest key, zero entry when empty
  function automatic entry_t best_level(state_t s);
    entry_t best;
    best = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (s.entry[i].vld && (!best.vld || (s.entry[i].key < best.key))) begin
        best = s.entry[i];
      end
    end
    return best;
  endfunction

  logic [ENTRIES_N - 1:0] match_vec;
  logic [ENTRIES_N - 1:0] free_vec;
  logic [ENTRIES_N - 1:0] fill_vec;
  state_t                 nxt;
  entry_t                 lv0_cur;
  entry_t                 lv0_nxt;

  // Keys are unique so at most one match
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      match_vec[i] = i_state.entry[i].vld & (i_state.entry[i].key == i_key);
      free_vec[i]  = ~i_state.entry[i].vld;
    end
  end

  // Lowest free slot, one-hot, zero when full
  assign fill_vec = free_vec & (~free_vec + 1'b1);

  always_comb begin
    nxt = i_state;
    case (i_cmd)
      CMD_ADD: begin
        for (int i = 0; i < ENTRIES_N; i++) begin
          if (match_vec[i]) begin
            nxt.entry[i].volume = sat_add(i_state.entry[i].volume, i_volume);
          end else if (!(|match_vec) && fill_vec[i]) begin
            nxt.entry[i] = '{vld: 1'b1, key: i_key, volume: i_volume};
          end
        end
      end
      CMD_DEL: begin
        for (int i = 0; i < ENTRIES_N; i++) begin
          if (match_vec[i]) begin
            // Level empties at or below zero
            if (i_state.entry[i].volume <= i_volume) begin
              nxt.entry[i] = '0;
            end else begin
              nxt.entry[i].volume = i_state.entry[i].volume - i_volume;
            end
          end
        end
      end
      CMD_CLR: begin
        nxt.entry = '0;
      end
      default: begin
        nxt = i_state;
      end
    endcase
    // Size recounted from the new valids
    nxt.listsize = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      nxt.listsize = nxt.listsize + listsize_t'(nxt.entry[i].vld);
    end
  end

  assign o_state = nxt;

  // Level zero before and after
  assign lv0_cur = best_level(i_state);
  assign lv0_nxt = best_level(nxt);

  // Clear is silent, next add reports against an empty book
  assign o_notify.vld    = (i_cmd != CMD_CLR) &
                           ((lv0_cur.key != lv0_nxt.key) | (lv0_cur.volume != lv0_nxt.volume));
  assign o_notify.id     = i_id;
  assign o_notify.key    = lv0_nxt.key;
  assign o_notify.volume = lv0_nxt.volume;

endmodule

`default_nettype wire

// File: hw/state_fwd.sv
// Write-back hazard unit, S1 collision capture and S2 state select with priority
`timescale 1ns/1ps
`default_nettype none

module state_fwd
  import book_pkg::*;
  import pipe_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  // Stage ids from the pipeline
  input  wire logic   i_s1_vld,
  input  wire id_t    i_s1_id,
  input  wire logic   i_s2_vld,
  input  wire id_t    i_s2_id,
  // Write-back in flight and table read data
  input  wire wrbk_t  i_wrbk,
  input  wire state_t i_rd_state,
  // Table read suppress and selected S2 state
  output logic        o_rd_kill,
  output state_t      o_s2_state
);

  logic   s1_hit;
  logic   cap_vld_r;
  state_t cap_state_r;
  logic   s2_cur_hit;
  logic   s2_cap_hit;

  // S1 id matches the write-back landing this edge
  // Table read would race the write, take the write-back state instead
  assign s1_hit    = i_s1_vld & i_wrbk.vld & (i_wrbk.id == i_s1_id);
  assign o_rd_kill = s1_hit;

  // Capture valid follows S1 into S2
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_vld_r <= 1'b0;
    end else begin
      cap_vld_r <= s1_hit;
    end
  end

  // Captured state, only meaningful with cap_vld_r
  always_ff @(posedge clk) begin
    if (i_s1_vld) begin
      cap_state_r <= i_wrbk.state;
    end
  end

  // Update two cycles ahead is in write-back now
  assign s2_cur_hit = i_s2_vld & i_wrbk.vld & (i_wrbk.id == i_s2_id);
  // Update three cycles ahead was caught in S1
  assign s2_cap_hit = i_s2_vld & cap_vld_r;

  // Newest state wins, table read is the fallback
  always_comb begin
    if (s2_cur_hit) begin
      o_s2_state = i_wrbk.state;
    end else if (s2_cap_hit) begin
      o_s2_state = cap_state_r;
    end else begin
      o_s2_state = i_rd_state;
    end
  end

  // Both hits need one id in back-to-back updates, barred at the input
  a_fwd_pri : assert property (@(posedge clk) disable iff (rst)
    !(s2_cur_hit && s2_cap_hit))
    else $error("state_fwd current and captured forwarding hit together");

endmodule

`default_nettype wire

// File: hw/state_table.sv
// Per-product book state memory, registered read in S1 and write from the S4 write-back
`timescale 1ns/1ps
`default_nettype none

module state_table
  import book_pkg::*;
  import pipe_pkg::*;
#(
  parameter int PRODUCTS_N = 16
) (
  input  wire logic   clk,
  // Read port, data returned one cycle later
  input  wire logic   i_rd_en,
  input  wire id_t    i_rd_id,
  output state_t      o_rd_state,
  // Write port
  input  wire wrbk_t  i_wrbk
);

  // Contents undefined until a clear is written
  state_t mem [PRODUCTS_N];

  // Registered read, holds last data when idle
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_state <= mem[i_rd_id];
    end
  end

  // Write lands at the edge that samples it
  always_ff @(posedge clk) begin
    if (i_wrbk.vld) begin
      mem[i_wrbk.id] <= i_wrbk.state;
    end
  end

  // Ids outside the populated depth would alias
  a_rd_range : assert property (@(posedge clk) i_rd_en |-> (i_rd_id < PRODUCTS_N))
    else $error("state_table read id %0d out of range", i_rd_id);

  a_wr_range : assert property (@(posedge clk) i_wrbk.vld |-> (i_wrbk.id < PRODUCTS_N))
    else $error("state_table write id %0d out of range", i_wrbk.id);

endmodule

`default_nettype wire

// File: hw/pipe_pkg.sv
// Pipeline transport structs for the update strobe, the write-back and the notify bus
`default_nettype none

package pipe_pkg;

  import book_pkg::*;

  // Update strobe, vld high for a single cycle
  typedef struct packed {
    logic    vld;
    id_t     id;
    cmd_t    cmd;
    key_t    key;
    volume_t volume;
  } upd_t;

  // S4 write-back of a product's new state
  typedef struct packed {
    logic   vld;
    id_t    id;
    state_t state;
  } wrbk_t;

  // Level zero change notification
  typedef struct packed {
    logic    vld;
    id_t     id;
    key_t    key;
    volume_t volume;
  } notify_t;

endpackage

`default_nettype wire

// File: hw/book_pkg.sv
// Book content types shared by the execute unit, the state table and the pipeline
`default_nettype none

package book_pkg;

  // Field widths
  localparam int ID_W      = 4;
  localparam int KEY_W     = 8;
  localparam int VOLUME_W  = 8;

  // List entries held per product
  localparam int ENTRIES_N = 4;

  // Product id, also the state table address
  typedef logic [ID_W - 1:0]     id_t;

  // Price key, smaller is better
  typedef logic [KEY_W - 1:0]    key_t;

  // Volume at a level, saturates at all ones
  typedef logic [VOLUME_W - 1:0] volume_t;

  // Count of valid entries, 0 to ENTRIES_N
  typedef logic [$clog2(ENTRIES_N + 1) - 1:0] listsize_t;

  // Update commands
  typedef enum logic [1:0] {
    CMD_ADD = 2'd0,
    CMD_DEL = 2'd1,
    CMD_CLR = 2'd2
  } cmd_t;

  // One price level
  typedef struct packed {
    logic    vld;
    key_t    key;
    volume_t volume;
  } entry_t;

  // Whole book of one product, entries kept unsorted
  typedef struct packed {
    entry_t [ENTRIES_N - 1:0] entry;
    listsize_t                listsize;
  } state_t;

endpackage

`default_nettype wire
